/* Makefile */
# Verilator build and run of the board shell testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_x68k_shell
FILELIST  := src.f
BUILD_DIR := obj_dir

.PHONY: sim clean

# Build and run, a failing check makes the binary exit non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* rtl/audio_compressor.sv */
// Audio channel stage that mixes core and synth, saturates and soft-compresses
`timescale 1ns/1ps

module audio_compressor import shell_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  logic    sample_stb,
	input  sample_t core_sample,
	input  sample_t synth_sample,
	input  logic    synth_mute,
	input  logic    curve_sel,
	output logic    out_stb,
	output sample_t out_sample
);

	// Piecewise curve, linear gain below the knee, flat slope above it
	function automatic logic [19:0] curve(input logic [16:0] mag, input int x,
		input int a, input int f, input int b);
		logic [19:0] m;
		m = 20'(mag);
		if (m < 20'(x))
			return m * 20'(a);
		return (m - 20'(x)) / 20'(f) + 20'(b);
	endfunction

	// Stage 1 registers
	logic    s1_stb;
	logic    s1_curve;
	sample_t s1_sum;

	// Stage 2 registers
	logic        s2_stb;
	logic        s2_curve;
	logic        s2_neg;
	logic [16:0] s2_mag;

	// Combinational helpers
	sample_t            synth_eff;
	logic signed [16:0] sum_full;
	sample_t            sum_sat;
	logic signed [16:0] s1_wide;
	logic [16:0]        mag;
	logic [19:0]        cmp_soft;
	logic [19:0]        cmp_strong;
	logic [19:0]        cmp_sel;
	logic [15:0]        cmp_cap;

	////////////////////////////////////////////////////////////
	// Stage 1, mix and saturate
	////////////////////////////////////////////////////////////

	assign synth_eff = synth_mute ? '0 : synth_sample;
	assign sum_full  = 17'(core_sample) + 17'(synth_eff);

	always_comb begin
		if (sum_full > SAMPLE_MAX)
			sum_sat = SAMPLE_MAX;
		else if (sum_full < SAMPLE_MIN)
			sum_sat = SAMPLE_MIN;
		else
			sum_sat = sample_t'(sum_full);
	end

	always_ff @(posedge clk_sys) begin
		s1_sum   <= sum_sat;
		s1_curve <= curve_sel;
	end

	////////////////////////////////////////////////////////////
	// Stage 2, magnitude and sign
	////////////////////////////////////////////////////////////

	// 17 bits so that -32768 keeps its full magnitude
	assign s1_wide = 17'(s1_sum);
	assign mag     = (s1_wide < 0) ? 17'(-s1_wide) : 17'(s1_wide);

	always_ff @(posedge clk_sys) begin
		s2_mag   <= mag;
		s2_neg   <= s1_sum[15];
		s2_curve <= s1_curve;
	end

	////////////////////////////////////////////////////////////
	// Stage 3, compress, cap and restore sign
	////////////////////////////////////////////////////////////

	assign cmp_soft   = curve(s2_mag, COMP_X1, COMP_A1, COMP_F1, COMP_B1);
	assign cmp_strong = curve(s2_mag, COMP_X2, COMP_A2, COMP_F2, COMP_B2);
	assign cmp_sel    = s2_curve ? cmp_strong : cmp_soft;
	// Top of the upper segment lands just past full scale
	assign cmp_cap    = (cmp_sel > 20'(SAMPLE_MAX)) ? 16'(SAMPLE_MAX) : cmp_sel[15:0];

	always_ff @(posedge clk_sys) begin
		out_sample <= s2_neg ? -sample_t'(cmp_cap) : sample_t'(cmp_cap);
	end

	// Strobe follows the data through all three stages
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			s1_stb  <= 1'b0;
			s2_stb  <= 1'b0;
			out_stb <= 1'b0;
		end else begin
			s1_stb  <= sample_stb;
			s2_stb  <= s1_stb;
			out_stb <= s2_stb;
		end
	end

	// Fixed three cycle latency in both directions
	a_stb_latency: assert property (@(posedge clk_sys) disable iff (!rst_n)
		sample_stb |-> ##3 out_stb);
	a_stb_origin: assert property (@(posedge clk_sys) disable iff (!rst_n)
		out_stb |-> $past(sample_stb, 3));

endmodule

/* rtl/host_session.sv */
// Host session control with core run gating and image loader write handshake
`timescale 1ns/1ps

module host_session (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic reset_btn,
	input  logic reset_req,
	input  logic ioctl_download,
	input  logic ioctl_wr,
	input  logic ldr_ack,
	output logic ldr_wr,
	output logic ldr_done,
	output logic ldr_aen,
	output logic core_run
);

	// Delayed copies for edge detection
	logic download_d;
	logic ack_d;
	logic reset_req_d;

	// Session flags
	logic dl_seen;
	logic init_done;
	logic reset_q;

	////////////////////////////////////////////////////////////
	// Session reset
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download_d  <= 1'b0;
			reset_req_d <= 1'b0;
			dl_seen     <= 1'b0;
			init_done   <= 1'b0;
			reset_q     <= 1'b0;
		end else begin
			download_d  <= ioctl_download;
			reset_req_d <= reset_req;
			// Core is held until the first image transfer starts
			if (!download_d && ioctl_download)
				dl_seen <= 1'b1;
			// Host releases the initial reset by dropping its request
			if (reset_req_d && !reset_req)
				init_done <= 1'b1;
			// Button or host request, seen one cycle late
			reset_q <= reset_btn | reset_req;
		end
	end

	assign core_run = dl_seen & init_done & ~reset_q;

	////////////////////////////////////////////////////////////
	// Loader handshake
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ack_d    <= 1'b0;
			ldr_wr   <= 1'b0;
			ldr_done <= 1'b0;
		end else begin
			ack_d <= ldr_ack;
			// Acknowledge edge ends the pending byte
			if (!ack_d && ldr_ack && ldr_wr)
				ldr_wr <= 1'b0;
			// A new host byte wins over a late acknowledge
			if (ioctl_wr && !ldr_done)
				ldr_wr <= 1'b1;
			// End of the first download locks the loader out
			if (download_d && !ioctl_download)
				ldr_done <= 1'b1;
		end
	end

	// Address enable only while the first image is streaming
	assign ldr_aen = ioctl_download & ~ldr_done;

	// No new byte is started once the loader is locked out
	a_no_wr_after_done: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ldr_done |-> !$rose(ldr_wr));

endmodule

/* rtl/shell_pkg.sv */
// Board shell package with audio and video types, compressor curves and display modes
package shell_pkg;

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	// Signed PCM sample as delivered by core and synth
	typedef logic signed [15:0] sample_t;

	// One colour channel of the core video
	typedef logic [7:0] pixel_t;

	// Saturation limits of sample_t
	localparam sample_t SAMPLE_MAX = 16'sh7FFF;
	localparam sample_t SAMPLE_MIN = 16'sh8000;

	////////////////////////////////////////////////////////////
	// Compressor curves
	////////////////////////////////////////////////////////////

	// Soft curve, gain 2 up to the knee then a 1/4 slope
	localparam int COMP_X1 = 14044;
	localparam int COMP_A1 = 2;
	localparam int COMP_F1 = 4;
	localparam int COMP_B1 = 28088;

	// Strong curve, gain 4 up to the knee then a 1/8 slope
	localparam int COMP_X2 = 7400;
	localparam int COMP_A2 = 4;
	localparam int COMP_F2 = 8;
	localparam int COMP_B2 = 29600;

	////////////////////////////////////////////////////////////
	// Synth info display modes
	////////////////////////////////////////////////////////////

	// LCD hidden, info request pulses disabled
	localparam logic [1:0] INFO_OFF  = 2'd0;
	// Host info popup on synth mode change
	localparam logic [1:0] INFO_REQ  = 2'd1;
	// LCD overlay always shown
	localparam logic [1:0] INFO_ON   = 2'd2;
	// LCD overlay shown for a while after each LCD update
	localparam logic [1:0] INFO_AUTO = 2'd3;

endpackage

/* rtl/synth_display.sv */
// Synth LCD overlay with hold timer, info request pulse and registered video path
`timescale 1ns/1ps

module synth_display import shell_pkg::*; #(
	parameter int LCD_HOLD_CYCLES = 64
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [1:0] info_mode,
	input  logic       synth_newmode,
	input  logic       lcd_en,
	input  logic       lcd_pix,
	input  logic       lcd_update,
	input  pixel_t     red_in,
	input  pixel_t     green_in,
	input  pixel_t     blue_in,
	input  logic       hsync_in,
	input  logic       vsync_in,
	input  logic       de_in,
	output logic       info_req,
	output logic       lcd_on,
	output pixel_t     red,
	output pixel_t     green,
	output pixel_t     blue,
	output logic       hsync,
	output logic       vsync,
	output logic       de
);

	// Counter wide enough for the full hold value
	localparam int CNT_W = $clog2(LCD_HOLD_CYCLES + 1);

	logic             newmode_d;
	logic             update_d;
	logic [CNT_W-1:0] hold_cnt;
	logic             lcd_show;

	////////////////////////////////////////////////////////////
	// Info request and LCD hold timer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			newmode_d <= 1'b0;
			update_d  <= 1'b0;
			info_req  <= 1'b0;
			lcd_on    <= 1'b0;
			hold_cnt  <= '0;
		end else begin
			newmode_d <= synth_newmode;
			update_d  <= lcd_update;
			// Host popup only when the user asked for it
			info_req  <= (newmode_d ^ synth_newmode) && (info_mode == INFO_REQ);

			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			if (info_mode == INFO_ON) begin
				lcd_on <= 1'b1;
			end else if (info_mode != INFO_AUTO) begin
				lcd_on <= 1'b0;
			end else begin
				// Timer expiry hides the LCD
				if (hold_cnt == '0)
					lcd_on <= 1'b0;
				// Fresh LCD content restarts the hold
				if (update_d ^ lcd_update) begin
					lcd_on   <= 1'b1;
					hold_cnt <= CNT_W'(LCD_HOLD_CYCLES);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel overlay
	////////////////////////////////////////////////////////////

	assign lcd_show = lcd_on & lcd_en;

	// LCD dot fills the top two bits, video dimmed underneath
	always_ff @(posedge clk_sys) begin
		red   <= lcd_show ? {{2{lcd_pix}}, red_in[7:2]}   : red_in;
		green <= lcd_show ? {{2{lcd_pix}}, green_in[7:2]} : green_in;
		blue  <= lcd_show ? {{2{lcd_pix}}, blue_in[7:2]}  : blue_in;
		hsync <= hsync_in;
		vsync <= vsync_in;
		de    <= de_in;
	end

	// Mode changes are slow host events, never two in a row
	a_info_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		info_req |=> !info_req);

endmodule

/* rtl/x68k_shell.sv */
// Board shell top joining host session, stereo audio compressor and synth display
`timescale 1ns/1ps

module x68k_shell import shell_pkg::*; #(
	parameter int LCD_HOLD_CYCLES = 64
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	// Host session and loader
	input  logic       reset_btn,
	input  logic       reset_req,
	input  logic       ioctl_download,
	input  logic       ioctl_wr,
	input  logic       ldr_ack,
	output logic       ldr_wr,
	output logic       ldr_done,
	output logic       ldr_aen,
	output logic       core_run,
	// Audio, shared controls first
	input  logic       synth_mute,
	input  logic       curve_sel,
	input  logic       sample_stb_l,
	input  sample_t    core_sample_l,
	input  sample_t    synth_sample_l,
	output logic       out_stb_l,
	output sample_t    out_sample_l,
	input  logic       sample_stb_r,
	input  sample_t    core_sample_r,
	input  sample_t    synth_sample_r,
	output logic       out_stb_r,
	output sample_t    out_sample_r,
	// Synth display and video
	input  logic [1:0] info_mode,
	input  logic       synth_newmode,
	input  logic       lcd_en,
	input  logic       lcd_pix,
	input  logic       lcd_update,
	input  pixel_t     red_in,
	input  pixel_t     green_in,
	input  pixel_t     blue_in,
	input  logic       hsync_in,
	input  logic       vsync_in,
	input  logic       de_in,
	output logic       info_req,
	output logic       lcd_on,
	output pixel_t     red,
	output pixel_t     green,
	output pixel_t     blue,
	output logic       hsync,
	output logic       vsync,
	output logic       de
);

	// Loader strobe doubles as the host wait level
	host_session u_session (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.reset_btn(reset_btn), .reset_req(reset_req),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ldr_ack(ldr_ack),
		.ldr_wr(ldr_wr), .ldr_done(ldr_done), .ldr_aen(ldr_aen), .core_run(core_run)
	);

	// Left channel
	audio_compressor u_audio_l (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.sample_stb(sample_stb_l), .core_sample(core_sample_l),
		.synth_sample(synth_sample_l), .synth_mute(synth_mute), .curve_sel(curve_sel),
		.out_stb(out_stb_l), .out_sample(out_sample_l)
	);

	// Right channel
	audio_compressor u_audio_r (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.sample_stb(sample_stb_r), .core_sample(core_sample_r),
		.synth_sample(synth_sample_r), .synth_mute(synth_mute), .curve_sel(curve_sel),
		.out_stb(out_stb_r), .out_sample(out_sample_r)
	);

	synth_display #(
		.LCD_HOLD_CYCLES(LCD_HOLD_CYCLES)
	) u_display (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.info_mode(info_mode), .synth_newmode(synth_newmode),
		.lcd_en(lcd_en), .lcd_pix(lcd_pix), .lcd_update(lcd_update),
		.red_in(red_in), .green_in(green_in), .blue_in(blue_in),
		.hsync_in(hsync_in), .vsync_in(vsync_in), .de_in(de_in),
		.info_req(info_req), .lcd_on(lcd_on),
		.red(red), .green(green), .blue(blue),
		.hsync(hsync), .vsync(vsync), .de(de)
	);

endmodule

/* src.f */
rtl/shell_pkg.sv
rtl/host_session.sv
rtl/audio_compressor.sv
rtl/synth_display.sv
rtl/x68k_shell.sv
test/tb_x68k_shell.sv

/* test/shell_stim.mem */
// Columns op_flags_sub_a_b_expected, op 1 audio 2 drain 3 set 4 pulse 5 check 6 wait 7 count 8 video
// Set takes value in flags and steps in a, check steps a first, wait and count use a as cycles
// Reset state of all control outputs
5_0_08_0000_0000_00000000
// Session init and first download
3_1_01_0002_0000_00000000
3_0_01_0002_0000_00000000
5_0_00_0000_0000_00000000
3_1_02_0001_0000_00000000
5_0_08_0000_0000_00000009
// Loader bytes with held and released acknowledge
4_0_03_0000_0000_00000000
5_0_01_0000_0000_00000001
5_0_01_0003_0000_00000001
3_1_04_0001_0000_00000000
5_0_01_0000_0000_00000000
3_0_04_0000_0000_00000000
4_0_03_0000_0000_00000000
3_1_04_0000_0000_00000000
6_0_01_0005_0000_00000000
3_0_04_0000_0000_00000000
3_0_02_0001_0000_00000000
5_0_08_0000_0000_00000005
4_0_03_0000_0000_00000000
5_0_01_0000_0000_00000000
// Reset button drops core_run for one cycle
3_1_00_0001_0000_00000000
5_0_00_0000_0000_00000000
3_0_00_0001_0000_00000000
5_0_00_0000_0000_00000001
// Audio samples, both curves, saturation and mute
1_0_00_03E8_01F4_00000BB8
1_C_00_F830_012C_0000F2B8
1_0_00_7530_2710_00007FFF
1_C_00_8AD0_D8F0_00008001
1_0_00_4E20_0000_00007389
1_1_00_0064_7000_000000C8
1_6_00_03E8_01F4_00001770
1_A_00_EC78_F448_00008C15
1_2_00_1CE7_0000_0000739C
1_6_00_7FFF_0000_00007FFF
2_0_00_0010_0000_00000000
// Video overlay and pass through
8_0_00_3412_05AB_05AB3412
3_2_05_0000_0000_00000000
3_1_07_0000_0000_00000000
3_1_08_0001_0000_00000000
5_0_04_0000_0000_00000001
8_0_00_3412_02AB_02EACDC4
3_0_08_0000_0000_00000000
8_0_00_80FF_0703_0700203F
3_0_07_0000_0000_00000000
8_0_00_80FF_0003_000380FF
// LCD hold in auto mode
3_3_05_0001_0000_00000000
5_0_04_0000_0000_00000000
3_1_09_0001_0000_00000000
5_0_04_0000_0000_00000001
5_0_04_0007_0000_00000001
6_0_04_0004_0000_00000000
// Info request pulses by mode
3_1_06_0000_0000_00000000
7_0_05_0004_0000_00000000
3_1_05_0000_0000_00000000
3_0_06_0000_0000_00000000
7_0_05_0004_0000_00000001
3_0_05_0000_0000_00000000
3_1_06_0000_0000_00000000
7_0_05_0004_0000_00000000
0_0_00_0000_0000_00000000

/* test/tb_x68k_shell.sv */
// Testbench for the board shell, replays stimulus records and checks every response
`timescale 1ns/1ps

module tb_x68k_shell import shell_pkg::*; ();

	// Record layout, op flags sub a b expected from the top bit down
	localparam int MAX_RECORDS = 128;

	localparam logic [3:0] OP_END   = 4'd0;
	localparam logic [3:0] OP_AUDIO = 4'd1;
	localparam logic [3:0] OP_DRAIN = 4'd2;
	localparam logic [3:0] OP_SET   = 4'd3;
	localparam logic [3:0] OP_PULSE = 4'd4;
	localparam logic [3:0] OP_CHECK = 4'd5;
	localparam logic [3:0] OP_WAIT  = 4'd6;
	localparam logic [3:0] OP_COUNT = 4'd7;
	localparam logic [3:0] OP_VIDEO = 4'd8;

	logic [79:0] records [MAX_RECORDS];

	logic       clk_sys;
	logic       rst_n;
	logic       reset_btn;
	logic       reset_req;
	logic       ioctl_download;
	logic       ioctl_wr;
	logic       ldr_ack;
	logic       ldr_wr;
	logic       ldr_done;
	logic       ldr_aen;
	logic       core_run;
	logic       synth_mute;
	logic       curve_sel;
	logic       sample_stb_l;
	sample_t    core_sample_l;
	sample_t    synth_sample_l;
	logic       out_stb_l;
	sample_t    out_sample_l;
	logic       sample_stb_r;
	sample_t    core_sample_r;
	sample_t    synth_sample_r;
	logic       out_stb_r;
	sample_t    out_sample_r;
	logic [1:0] info_mode;
	logic       synth_newmode;
	logic       lcd_en;
	logic       lcd_pix;
	logic       lcd_update;
	pixel_t     red_in;
	pixel_t     green_in;
	pixel_t     blue_in;
	logic       hsync_in;
	logic       vsync_in;
	logic       de_in;
	logic       info_req;
	logic       lcd_on;
	pixel_t     red;
	pixel_t     green;
	pixel_t     blue;
	logic       hsync;
	logic       vsync;
	logic       de;

	// Rising edges since time zero
	int unsigned cycle = 0;

	// Audio results still in flight, one queue pair per channel
	int unsigned due_l[$];
	logic [15:0] want_l[$];
	int unsigned due_r[$];
	logic [15:0] want_r[$];

	////////////////////////////////////////////////////////////
	// Clock and DUT
	////////////////////////////////////////////////////////////

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
		cycle <= cycle + 1;

	x68k_shell #(
		.LCD_HOLD_CYCLES(8)
	) UUT (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.reset_btn(reset_btn), .reset_req(reset_req),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ldr_ack(ldr_ack),
		.ldr_wr(ldr_wr), .ldr_done(ldr_done), .ldr_aen(ldr_aen), .core_run(core_run),
		.synth_mute(synth_mute), .curve_sel(curve_sel),
		.sample_stb_l(sample_stb_l), .core_sample_l(core_sample_l),
		.synth_sample_l(synth_sample_l), .out_stb_l(out_stb_l), .out_sample_l(out_sample_l),
		.sample_stb_r(sample_stb_r), .core_sample_r(core_sample_r),
		.synth_sample_r(synth_sample_r), .out_stb_r(out_stb_r), .out_sample_r(out_sample_r),
		.info_mode(info_mode), .synth_newmode(synth_newmode),
		.lcd_en(lcd_en), .lcd_pix(lcd_pix), .lcd_update(lcd_update),
		.red_in(red_in), .green_in(green_in), .blue_in(blue_in),
		.hsync_in(hsync_in), .vsync_in(vsync_in), .de_in(de_in),
		.info_req(info_req), .lcd_on(lcd_on),
		.red(red), .green(green), .blue(blue),
		.hsync(hsync), .vsync(vsync), .de(de)
	);

	////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////

	task automatic stop_on_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at cycle %0d", cycle);
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// Control outputs packed into one word, bit 0 is core_run
	function automatic logic [31:0] probe(input logic [7:0] id);
		logic [7:0] status;
		status = {out_stb_r, out_stb_l, info_req, lcd_on, ldr_aen, ldr_done, ldr_wr, core_run};
		if (id == 8'd8)
			return {24'h0, status};
		return {31'h0, status[id[2:0]]};
	endfunction

	// Each strobe must show up exactly on its due cycle and never elsewhere
	task automatic watch_audio();
		if (due_l.size() > 0 && due_l[0] == cycle) begin
			check_equal("left strobe", 32'd1, {31'h0, out_stb_l});
			check_equal("left sample", {16'h0, want_l[0]}, {16'h0, out_sample_l});
			due_l.delete(0);
			want_l.delete(0);
		end else begin
			check_equal("left idle", 32'd0, {31'h0, out_stb_l});
		end
		if (due_r.size() > 0 && due_r[0] == cycle) begin
			check_equal("right strobe", 32'd1, {31'h0, out_stb_r});
			check_equal("right sample", {16'h0, want_r[0]}, {16'h0, out_sample_r});
			due_r.delete(0);
			want_r.delete(0);
		end else begin
			check_equal("right idle", 32'd0, {31'h0, out_stb_r});
		end
	endtask

	// Outputs are settled at the falling edge, inputs change right after
	task automatic next_cycle();
		@(negedge clk_sys);
		watch_audio();
		sample_stb_l = 1'b0;
		sample_stb_r = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_input(input logic [7:0] id, input logic [3:0] value);
		case (id)
			8'd0: reset_btn      = value[0];
			8'd1: reset_req      = value[0];
			8'd2: ioctl_download = value[0];
			8'd3: ioctl_wr       = value[0];
			8'd4: ldr_ack        = value[0];
			8'd5: info_mode      = value[1:0];
			8'd6: synth_newmode  = value[0];
			8'd7: lcd_en         = value[0];
			8'd8: lcd_pix        = value[0];
			8'd9: lcd_update     = value[0];
			default: begin
				$display("Stimulus names input %0d, which does not exist", id);
				stop_on_failure();
			end
		endcase
	endtask

	// Flags are pair, right, strong curve and mute from bit 3 down
	task automatic drive_audio(input logic [3:0] flags, input sample_t core,
		input sample_t synth, input logic [15:0] expected);
		// Paired record lands on the same cycle as the one before
		if (!flags[3])
			next_cycle();
		synth_mute = flags[0];
		curve_sel  = flags[1];
		if (flags[2]) begin
			sample_stb_r   = 1'b1;
			core_sample_r  = core;
			synth_sample_r = synth;
			due_r.push_back(cycle + 3);
			want_r.push_back(expected);
		end else begin
			sample_stb_l   = 1'b1;
			core_sample_l  = core;
			synth_sample_l = synth;
			due_l.push_back(cycle + 3);
			want_l.push_back(expected);
		end
	endtask

	task automatic run_record(input int idx, input logic [79:0] rec);
		logic [3:0]  op;
		logic [3:0]  flags;
		logic [7:0]  sub;
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] want;
		string       name;
		int          n;
		int          hits;
		op    = rec[79:76];
		flags = rec[75:72];
		sub   = rec[71:64];
		a     = rec[63:48];
		b     = rec[47:32];
		want  = rec[31:0];
		name  = $sformatf("record %0d", idx);
		n     = 0;
		hits  = 0;
		case (op)
			OP_AUDIO: drive_audio(flags, a, b, want[15:0]);
			OP_DRAIN: begin
				while (due_l.size() + due_r.size() != 0) begin
					if (n == int'(a)) begin
						$display("%s: audio results still missing after %0d cycles", name, n);
						stop_on_failure();
					end
					next_cycle();
					n++;
				end
			end
			OP_SET: begin
				drive_input(sub, flags);
				repeat (a) next_cycle();
			end
			OP_PULSE: begin
				drive_input(sub, 4'd1);
				next_cycle();
				drive_input(sub, 4'd0);
			end
			OP_CHECK: begin
				repeat (a) next_cycle();
				check_equal(name, want, probe(sub));
			end
			OP_WAIT: begin
				while (probe(sub) !== want) begin
					if (n == int'(a)) begin
						$display("%s: output %0d never reached %h within %0d cycles",
							name, sub, want, n);
						stop_on_failure();
					end
					next_cycle();
					n++;
				end
			end
			OP_COUNT: begin
				repeat (a) begin
					next_cycle();
					if (probe(sub) == 32'd1)
						hits++;
				end
				check_equal(name, want, 32'(hits));
			end
			OP_VIDEO: begin
				red_in   = a[7:0];
				green_in = a[15:8];
				blue_in  = b[7:0];
				{de_in, vsync_in, hsync_in} = b[10:8];
				next_cycle();
				check_equal(name, want, {5'h0, de, vsync, hsync, blue, green, red});
			end
			default: begin
				$display("%s holds opcode %0d, which is not defined", name, op);
				stop_on_failure();
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int idx;
		clk_sys        = 1'b0;
		rst_n          = 1'b0;
		reset_btn      = 1'b0;
		reset_req      = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ldr_ack        = 1'b0;
		synth_mute     = 1'b0;
		curve_sel      = 1'b0;
		sample_stb_l   = 1'b0;
		core_sample_l  = '0;
		synth_sample_l = '0;
		sample_stb_r   = 1'b0;
		core_sample_r  = '0;
		synth_sample_r = '0;
		info_mode      = INFO_OFF;
		synth_newmode  = 1'b0;
		lcd_en         = 1'b0;
		lcd_pix        = 1'b0;
		lcd_update     = 1'b0;
		red_in         = '0;
		green_in       = '0;
		blue_in        = '0;
		hsync_in       = 1'b0;
		vsync_in       = 1'b0;
		de_in          = 1'b0;
		$readmemh("test/shell_stim.mem", records);

		// Four rising edges in reset
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;

		idx = 0;
		while (idx < MAX_RECORDS && records[idx][79:76] !== OP_END) begin
			run_record(idx, records[idx]);
			idx++;
		end

		if (idx == MAX_RECORDS) begin
			$display("Stimulus file ran out without an end record");
			stop_on_failure();
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule
